// File: verilog.f
+incdir+.
fir_data_pkg.sv
fir_ctrl_pkg.sv
fir_tap.sv
fir_sum_tree.sv
fir_controller.sv
coefficient_loader.sv
fir_filter.sv
tb_fir_filter.sv

// File: Bender.yml
package:
  name: fir_filter

sources:
  - include_dirs:
      - .
    files:
      - fir_data_pkg.sv
      - fir_ctrl_pkg.sv
      - fir_tap.sv
      - fir_sum_tree.sv
      - fir_controller.sv
      - coefficient_loader.sv
      - fir_filter.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fir_filter.sv

// File: tb_fir_filter.sv
//*************************************************
// FIR filter testbench
// Random samples and coefficient reloads against a reference model
//*************************************************

`timescale 1ns/1ns

`include "fir_defines.svh"

module tb_fir_filter;

  import fir_data_pkg::*;

  logic       tb_clk;
  logic       rst_n;
  logic       coeff_wr;
  coeff_num_t coeff_addr;
  coeff_t     coeff_data;
  logic       coeff_commit;
  logic       sample_valid;
  sample_t    sample_data;
  logic       coeff_busy;
  sum_t       result;
  logic       result_valid;

  // Reference model state
  coeff_t  staging [`FIR_TAPS];
  coeff_t  live [`FIR_TAPS];
  sample_t hist [`FIR_TAPS];
  sum_t    exp_q [$];
  int      due_q [$];
  int      cyc_count;
  logic    busy_prev;

  fir_filter dut0 (
    .tb_clk       (tb_clk),
    .rst_n        (rst_n),
    .coeff_wr     (coeff_wr),
    .coeff_addr   (coeff_addr),
    .coeff_data   (coeff_data),
    .coeff_commit (coeff_commit),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .coeff_busy   (coeff_busy),
    .result       (result),
    .result_valid (result_valid)
  );

  initial begin
    tb_clk = 1'b0;
    forever #20 tb_clk = ~tb_clk;
  end

  //*************************************************
  // Error handling and checks
  //*************************************************
  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // Sum over tap i of coefficient i times the i-th newest sample
  function automatic sum_t model_sum();
    longint acc;
    acc = 0;
    for (int i = 0; i < `FIR_TAPS; i++) begin
      acc += longint'(hist[i]) * longint'(live[i]);
    end
    return sum_t'(acc);
  endfunction

  //*************************************************
  // Model and result monitor
  //*************************************************
  // All values read here are the ones held just before the edge
  always @(posedge tb_clk) begin
    if (rst_n) begin
      // Reload finished, taps now hold what was staged
      if (busy_prev && !coeff_busy) begin
        for (int i = 0; i < `FIR_TAPS; i++) begin
          live[i] = staging[i];
        end
      end
      busy_prev = coeff_busy;
      if (coeff_wr) begin
        staging[coeff_addr] = coeff_data;
      end
      if (due_q.size() > 0 && due_q[0] == cyc_count) begin
        check("result_valid", result_valid, 1'b1);
        check("result", result, exp_q[0]);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end else if (result_valid) begin
        $display("ERROR: result_valid was high with no sample accepted two cycles before");
        abort_run();
      end
      // Accepted sample enters the history, dropped during a reload
      if (sample_valid && !coeff_busy) begin
        for (int i = `FIR_TAPS - 1; i > 0; i--) begin
          hist[i] = hist[i-1];
        end
        hist[0] = sample_data;
        exp_q.push_back(model_sum());
        due_q.push_back(cyc_count + 2);
      end
    end
    cyc_count++;
  end

  //*************************************************
  // Stimulus helpers
  //*************************************************
  // Move to the drive point of the next cycle with strobes low
  task automatic next_cycle();
    @(posedge tb_clk);
    #2;
    coeff_wr     = 1'b0;
    coeff_commit = 1'b0;
    sample_valid = 1'b0;
  endtask

  task automatic write_coeff(input coeff_num_t addr, input coeff_t data);
    next_cycle();
    coeff_wr   = 1'b1;
    coeff_addr = addr;
    coeff_data = data;
  endtask

  task automatic commit_coeffs();
    next_cycle();
    coeff_commit = 1'b1;
  endtask

  task automatic send_sample(input sample_t data);
    next_cycle();
    sample_valid = 1'b1;
    sample_data  = data;
  endtask

  task automatic wait_busy(input logic level);
    int n;
    for (n = 0; n < 100 && coeff_busy !== level; n++) begin
      next_cycle();
    end
    if (coeff_busy !== level) begin
      $display("ERROR: coeff_busy did not go to %0b within 100 cycles", level);
      abort_run();
    end
  endtask

  task automatic wait_drain();
    int n;
    for (n = 0; n < 100 && due_q.size() > 0; n++) begin
      next_cycle();
    end
    if (due_q.size() > 0) begin
      $display("ERROR: expected results still pending after 100 cycles");
      abort_run();
    end
  endtask

  // Random samples with zero to two idle cycles between them
  task automatic sample_stream(input int count);
    for (int i = 0; i < count; i++) begin
      send_sample(sample_t'($urandom));
      repeat ($urandom % 3) next_cycle();
    end
  endtask

  //*************************************************
  // Main sequence
  //*************************************************
  initial begin
    rst_n        = 1'b0;
    coeff_wr     = 1'b0;
    coeff_addr   = '0;
    coeff_data   = '0;
    coeff_commit = 1'b0;
    sample_valid = 1'b0;
    sample_data  = '0;
    cyc_count    = 0;
    busy_prev    = 1'b0;
    for (int i = 0; i < `FIR_TAPS; i++) begin
      staging[i] = '0;
      live[i]    = '0;
      hist[i]    = '0;
    end
    void'($urandom(76276));
    repeat (8) @(posedge tb_clk);
    #2;
    rst_n = 1'b1;

    // Idle outputs and a zero result with cleared coefficients
    check("coeff_busy", coeff_busy, 1'b0);
    check("result_valid", result_valid, 1'b0);
    send_sample(sample_t'($urandom));
    wait_drain();
    check("result", result, '0);

    // First coefficient set
    for (int i = 0; i < `FIR_TAPS; i++) begin
      write_coeff(coeff_num_t'(i), coeff_t'($urandom));
    end
    commit_coeffs();
    wait_busy(1'b1);
    wait_busy(1'b0);
    sample_stream(100);

    // Reload in mid-stream, last slot written after the commit
    for (int i = 0; i < `FIR_TAPS - 1; i++) begin
      write_coeff(coeff_num_t'(i), coeff_t'($urandom));
    end
    commit_coeffs();
    write_coeff(coeff_num_t'(`FIR_TAPS - 1), coeff_t'($urandom));
    wait_busy(1'b1);
    // These are dropped by the gate
    repeat (3) send_sample(sample_t'($urandom));
    wait_busy(1'b0);
    sample_stream(100);
    wait_drain();

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: fir_filter.sv
//*************************************************
// FIR filter top
// Controller, coefficient loader, tap chain and sum stage
//*************************************************

`timescale 1ns/1ns

`include "fir_defines.svh"

module fir_filter (
  input  logic                     tb_clk,
  input  logic                     rst_n,
  input  logic                     coeff_wr,
  input  fir_data_pkg::coeff_num_t coeff_addr,
  input  fir_data_pkg::coeff_t     coeff_data,
  input  logic                     coeff_commit,
  input  logic                     sample_valid,
  input  fir_data_pkg::sample_t    sample_data,
  output logic                     coeff_busy,
  output fir_data_pkg::sum_t       result,
  output logic                     result_valid
);

  import fir_data_pkg::*;

  // Loader handshake
  logic       modwait;
  logic       load_coeff;
  logic       clear_new_coeff;
  coeff_num_t coefficient_num;

  // Tap control
  logic       tap_load;
  coeff_num_t load_num;
  coeff_t     tap_coeff;
  logic       shift_en;

  // Entry 0 is the new sample, entry i+1 leaves tap i
  sample_t    sample_chain [`FIR_TAPS+1];
  product_t   tap_products [`FIR_TAPS];

  fir_controller u_ctrl (
    .tb_clk              (tb_clk),
    .rst_n               (rst_n),
    .coeff_wr            (coeff_wr),
    .coeff_addr          (coeff_addr),
    .coeff_data          (coeff_data),
    .coeff_commit        (coeff_commit),
    .sample_valid        (sample_valid),
    .sample_data         (sample_data),
    .load_coeff          (load_coeff),
    .coefficient_num     (coefficient_num),
    .clear_new_coeff     (clear_new_coeff),
    .new_coefficient_set (coeff_busy),
    .modwait             (modwait),
    .tap_load            (tap_load),
    .load_num            (load_num),
    .tap_coeff           (tap_coeff),
    .shift_en            (shift_en),
    .shift_data          (sample_chain[0])
  );

  coefficient_loader u_loader (
    .tb_clk              (tb_clk),
    .rst_n               (rst_n),
    .new_coefficient_set (coeff_busy),
    .modwait             (modwait),
    .load_coeff          (load_coeff),
    .clear_new_coeff     (clear_new_coeff),
    .coefficient_num     (coefficient_num)
  );

  //*************************************************
  // Tap chain
  //*************************************************
  for (genvar i = 0; i < `FIR_TAPS; i++) begin : g_tap
    // Each tap sees load_num relative to its own position
    localparam coeff_num_t TAP_NUM = coeff_num_t'(i);

    fir_tap u_tap (
      .tb_clk     (tb_clk),
      .rst_n      (rst_n),
      .shift_en   (shift_en),
      .sample_in  (sample_chain[i]),
      .sample_out (sample_chain[i+1]),
      .tap_load   (tap_load),
      .load_num   (coeff_num_t'(load_num - TAP_NUM)),
      .tap_coeff  (tap_coeff),
      .product    (tap_products[i])
    );
  end

  fir_sum_tree u_sum (
    .tb_clk       (tb_clk),
    .rst_n        (rst_n),
    .shift_en     (shift_en),
    .products     (tap_products),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

// File: coefficient_loader.sv
//*************************************************
// Coefficient loader
// Steps through all tap coefficients, paced by modwait
//*************************************************

`timescale 1ns/1ns

`include "fir_defines.svh"

module coefficient_loader (
  input  logic                     tb_clk,
  input  logic                     rst_n,
  input  logic                     new_coefficient_set,
  input  logic                     modwait,
  output logic                     load_coeff,
  output logic                     clear_new_coeff,
  output fir_data_pkg::coeff_num_t coefficient_num
);

  import fir_data_pkg::*;
  import fir_ctrl_pkg::*;

  // Number of the final coefficient in a reload
  localparam coeff_num_t LAST_NUM = coeff_num_t'(`FIR_TAPS - 1);

  loader_state_t state;

  //*************************************************
  // Sequencer
  //*************************************************
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      state           <= LD_IDLE;
      load_coeff      <= 1'b0;
      clear_new_coeff <= 1'b0;
      coefficient_num <= '0;
    end else begin
      // Strobes default low, raised for one cycle below
      load_coeff      <= 1'b0;
      clear_new_coeff <= 1'b0;
      case (state)
        LD_IDLE: begin
          // Flag seen, first load goes out next cycle
          if (new_coefficient_set) begin
            state      <= LD_LOAD;
            load_coeff <= 1'b1;
          end
        end
        LD_LOAD: begin
          // load_coeff is high during this cycle
          state <= LD_WAIT_BUSY;
        end
        LD_WAIT_BUSY: begin
          if (modwait) begin
            state <= LD_WAIT_DONE;
          end
        end
        LD_WAIT_DONE: begin
          if (!modwait) begin
            if (coefficient_num == LAST_NUM) begin
              // All taps loaded, ask for the flag clear
              state           <= LD_CLEAR;
              clear_new_coeff <= 1'b1;
              coefficient_num <= '0;
            end else begin
              state           <= LD_LOAD;
              load_coeff      <= 1'b1;
              coefficient_num <= coefficient_num + 1'b1;
            end
          end
        end
        LD_CLEAR: begin
          // Flag drops at the end of this cycle
          state <= LD_IDLE;
        end
        default: begin
          state <= LD_IDLE;
        end
      endcase
    end
  end

endmodule

// File: fir_controller.sv
//*************************************************
// FIR controller
// Coefficient staging, reload flag, copy cycle, sample gate
//*************************************************

`timescale 1ns/1ns

`include "fir_defines.svh"

module fir_controller (
  input  logic                     tb_clk,
  input  logic                     rst_n,
  input  logic                     coeff_wr,
  input  fir_data_pkg::coeff_num_t coeff_addr,
  input  fir_data_pkg::coeff_t     coeff_data,
  input  logic                     coeff_commit,
  input  logic                     sample_valid,
  input  fir_data_pkg::sample_t    sample_data,
  input  logic                     load_coeff,
  input  fir_data_pkg::coeff_num_t coefficient_num,
  input  logic                     clear_new_coeff,
  output logic                     new_coefficient_set,
  output logic                     modwait,
  output logic                     tap_load,
  output fir_data_pkg::coeff_num_t load_num,
  output fir_data_pkg::coeff_t     tap_coeff,
  output logic                     shift_en,
  output fir_data_pkg::sample_t    shift_data
);

  import fir_data_pkg::*;
  import fir_ctrl_pkg::*;

  coeff_t      staged [`FIR_TAPS];
  ctrl_state_t state;
  coeff_num_t  copy_num;

  //*************************************************
  // Staging bank and reload flag
  //*************************************************
  // Host writes land here at any time, taps see them only on reload
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `FIR_TAPS; i++) begin
        staged[i] <= '0;
      end
    end else if (coeff_wr) begin
      staged[coeff_addr] <= coeff_data;
    end
  end

  // A commit wins over a clear so a late commit still gets loaded
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      new_coefficient_set <= 1'b0;
    end else if (coeff_commit) begin
      new_coefficient_set <= 1'b1;
    end else if (clear_new_coeff) begin
      new_coefficient_set <= 1'b0;
    end
  end

  //*************************************************
  // Copy FSM
  //*************************************************
  // One COPY cycle per load_coeff, coefficient number latched on entry
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      state    <= CT_IDLE;
      copy_num <= '0;
    end else begin
      case (state)
        CT_IDLE: begin
          if (load_coeff) begin
            state    <= CT_COPY;
            copy_num <= coefficient_num;
          end
        end
        default: begin
          state <= CT_IDLE;
        end
      endcase
    end
  end

  // Copy strobe and busy indication share the COPY cycle
  assign tap_load  = (state == CT_COPY);
  assign modwait   = (state == CT_COPY);
  assign load_num  = copy_num;
  assign tap_coeff = staged[copy_num];

  // Samples pass only while no reload is pending
  assign shift_en   = sample_valid & ~new_coefficient_set;
  assign shift_data = sample_data;

endmodule

// File: fir_sum_tree.sv
//*************************************************
// FIR sum stage
// Registered sum of all tap products with valid pulse
//*************************************************

`timescale 1ns/1ns

`include "fir_defines.svh"

module fir_sum_tree (
  input  logic                   tb_clk,
  input  logic                   rst_n,
  input  logic                   shift_en,
  input  fir_data_pkg::product_t products [`FIR_TAPS],
  output fir_data_pkg::sum_t     result,
  output logic                   result_valid
);

  import fir_data_pkg::*;

  sum_t tap_sum;
  logic shift_d;

  // Sign-extend each product before adding
  always_comb begin
    tap_sum = '0;
    for (int i = 0; i < `FIR_TAPS; i++) begin
      tap_sum = tap_sum + sum_t'(products[i]);
    end
  end

  // Taps hold new contents the cycle after shift_en
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      shift_d      <= 1'b0;
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      shift_d      <= shift_en;
      result_valid <= shift_d;
      if (shift_d) begin
        result <= tap_sum;
      end
    end
  end

endmodule

// File: fir_tap.sv
//*************************************************
// FIR tap
// One delayed sample times one coefficient
//*************************************************

`timescale 1ns/1ns

module fir_tap (
  input  logic                     tb_clk,
  input  logic                     rst_n,
  input  logic                     shift_en,
  input  fir_data_pkg::sample_t    sample_in,
  output fir_data_pkg::sample_t    sample_out,
  input  logic                     tap_load,
  input  fir_data_pkg::coeff_num_t load_num,
  input  fir_data_pkg::coeff_t     tap_coeff,
  output fir_data_pkg::product_t   product
);

  import fir_data_pkg::*;

  // load_num arrives offset by this tap's position, zero selects it
  localparam coeff_num_t SELF_NUM = '0;

  sample_t sample_q;
  coeff_t  coeff_q;

  // Delay line stage
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      sample_q <= '0;
    end else if (shift_en) begin
      sample_q <= sample_in;
    end
  end

  // Coefficient register, written only during a reload copy
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      coeff_q <= '0;
    end else if (tap_load && (load_num == SELF_NUM)) begin
      coeff_q <= tap_coeff;
    end
  end

  assign sample_out = sample_q;

  // Signed full-width product
  assign product = sample_q * coeff_q;

endmodule

// File: fir_ctrl_pkg.sv
//*************************************************
// FIR control types
// State encodings of the coefficient loader and controller
//*************************************************

package fir_ctrl_pkg;

  // Coefficient loader sequence
  typedef enum logic [2:0] {
    LD_IDLE,
    LD_LOAD,
    LD_WAIT_BUSY,
    LD_WAIT_DONE,
    LD_CLEAR
  } loader_state_t;

  // Controller copy cycle
  typedef enum logic {
    CT_IDLE,
    CT_COPY
  } ctrl_state_t;

endpackage

// File: fir_data_pkg.sv
//*************************************************
// FIR datapath types
// Samples, coefficients, products, sums and tap index
//*************************************************

`include "fir_defines.svh"

package fir_data_pkg;

  // Signed input sample
  typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;

  // Signed filter coefficient
  typedef logic signed [`FIR_COEFF_W-1:0] coeff_t;

  // Full-width product of one tap
  typedef logic signed [`FIR_SAMPLE_W+`FIR_COEFF_W-1:0] product_t;

  // Filter output, no rounding or saturation
  typedef logic signed [`FIR_SUM_W-1:0] sum_t;

  // Tap index, used for coefficient number and staging address
  typedef logic [$clog2(`FIR_TAPS)-1:0] coeff_num_t;

endpackage

// File: fir_defines.svh
//*************************************************
// FIR filter sizing constants
// Tap count and datapath widths shared by all blocks
//*************************************************

`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// Number of taps, matches the 2-bit coefficient number
`define FIR_TAPS 4

// Input sample and coefficient widths
`define FIR_SAMPLE_W 16
`define FIR_COEFF_W 16

// Full product width plus two bits of growth for four taps
`define FIR_SUM_W 34

`endif
